// File: Bender.yml
package:
  name: mem_ctrl

sources:
  # design
  - memCtrlPkg.sv
  - memByteSequencer.sv
  - memWordAssembler.sv
  - memCtrl.sv

  # verification
  - target: test
    files:
      - memCtrl_props.sv
      - memCtrlTb.sv

// File: build.f
memCtrlPkg.sv
memByteSequencer.sv
memWordAssembler.sv
memCtrl.sv
memCtrl_props.sv
memCtrlTb.sv

// File: memByteSequencer.sv
`default_nettype none

module memByteSequencer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_rdy,
    input  logic                    i_ioBufferFull,

    input  logic                    i_fetchEn,
    input  memCtrlPkg::addr_t       i_fetchAddr,

    input  logic                    i_dcEn,
    input  logic                    i_dcStore,
    input  memCtrlPkg::accessSize_t i_dcSize,
    input  memCtrlPkg::addr_t       i_dcAddr,
    input  memCtrlPkg::word_t       i_dcData,

    output memCtrlPkg::memBusOut_t  o_bus,
    output memCtrlPkg::memBeat_t    o_beat
);

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_ISSUE = 2'd1,
        ST_DRAIN = 2'd2
    } state_t;

    state_t state;

    logic stall;
    logic accept;
    logic issue;
    logic lastByte;

    memCtrlPkg::addr_t baseAddr;
    memCtrlPkg::word_t storeWord;
    memCtrlPkg::lane_t byteIdx;
    memCtrlPkg::lane_t lastIdx;
    logic              isFetchQ;
    logic              isStoreQ;

    // index of the final byte for a data access
    function automatic memCtrlPkg::lane_t sizeToLastIdx(input memCtrlPkg::accessSize_t size);
        memCtrlPkg::lane_t idx;
        case (size)
            memCtrlPkg::SIZE_BYTE: idx = memCtrlPkg::lane_t'(0);
            memCtrlPkg::SIZE_HALF: idx = memCtrlPkg::lane_t'(1);
            default:               idx = memCtrlPkg::lane_t'(memCtrlPkg::BYTES_PER_WORD - 1);
        endcase
        return idx;
    endfunction

    // either stall source freezes byte issue
    assign stall = !i_rdy || i_ioBufferFull;

    assign accept   = (state == ST_IDLE) && !stall && (i_dcEn || i_fetchEn);
    assign issue    = (state == ST_ISSUE) && !stall;
    assign lastByte = (byteIdx == lastIdx);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            byteIdx  <= '0;
            lastIdx  <= '0;
            baseAddr <= '0;
            isFetchQ <= 1'b0;
            isStoreQ <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state   <= ST_ISSUE;
                        byteIdx <= '0;
                        // data port wins over fetch
                        if (i_dcEn) begin
                            baseAddr <= i_dcAddr;
                            isFetchQ <= 1'b0;
                            isStoreQ <= i_dcStore;
                            lastIdx  <= sizeToLastIdx(i_dcSize);
                        end else begin
                            baseAddr <= i_fetchAddr;
                            isFetchQ <= 1'b1;
                            isStoreQ <= 1'b0;
                            lastIdx  <= memCtrlPkg::lane_t'(memCtrlPkg::BYTES_PER_WORD - 1);
                        end
                    end
                end
                ST_ISSUE: begin
                    if (issue) begin
                        if (lastByte) begin
                            state <= ST_DRAIN;
                        end else begin
                            byteIdx <= byteIdx + memCtrlPkg::lane_t'(1);
                        end
                    end
                end
                ST_DRAIN: begin
                    // assembler reports done in this cycle
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // write data, low byte goes out first
    always_ff @(posedge clk) begin
        if (accept) begin
            storeWord <= i_dcEn ? i_dcData : '0;
        end else if (issue) begin
            storeWord <= storeWord >> memCtrlPkg::BYTE_WIDTH;
        end
    end

    always_comb begin
        // address holds during a stall since byteIdx only moves on issue
        o_bus.write = issue && isStoreQ;
        o_bus.addr  = baseAddr + memCtrlPkg::addr_t'(byteIdx);
        o_bus.data  = storeWord[memCtrlPkg::BYTE_WIDTH-1:0];

        o_beat.valid   = issue;
        o_beat.isFetch = isFetchQ;
        o_beat.isStore = isStoreQ;
        o_beat.last    = lastByte;
    end

endmodule

`default_nettype wire

// File: memCtrl.sv
`default_nettype none

module memCtrl (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_rdy,
    input  logic                    i_ioBufferFull,

    // ram
    input  memCtrlPkg::byte_t       i_memData,
    output logic                    o_memWrite,
    output memCtrlPkg::addr_t       o_memAddr,
    output memCtrlPkg::byte_t       o_memData,

    // instruction fetch
    input  logic                    i_fetchEn,
    input  memCtrlPkg::addr_t       i_fetchAddr,
    output logic                    o_fetchDone,
    output memCtrlPkg::word_t       o_fetchInst,

    // data port
    input  logic                    i_dcEn,
    input  logic                    i_dcStore,
    input  memCtrlPkg::accessSize_t i_dcSize,
    input  memCtrlPkg::addr_t       i_dcAddr,
    input  memCtrlPkg::word_t       i_dcData,
    output logic                    o_dcDone,
    output memCtrlPkg::word_t       o_dcData
);

    memCtrlPkg::memBusOut_t memBus;
    memCtrlPkg::memBeat_t   beat;

    memByteSequencer sequencer (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_fetchEn      (i_fetchEn),
        .i_fetchAddr    (i_fetchAddr),
        .i_dcEn         (i_dcEn),
        .i_dcStore      (i_dcStore),
        .i_dcSize       (i_dcSize),
        .i_dcAddr       (i_dcAddr),
        .i_dcData       (i_dcData),
        .o_bus          (memBus),
        .o_beat         (beat)
    );

    memWordAssembler assembler (
        .clk         (clk),
        .rst         (rst),
        .i_beat      (beat),
        .i_memData   (i_memData),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dcDone    (o_dcDone),
        .o_dcData    (o_dcData)
    );

    // ram port unpack
    assign o_memWrite = memBus.write;
    assign o_memAddr  = memBus.addr;
    assign o_memData  = memBus.data;

endmodule

`default_nettype wire

// File: memCtrlPkg.sv
`default_nettype none

package memCtrlPkg;

    localparam int ADDR_WIDTH     = 32;
    localparam int WORD_WIDTH     = 32;
    localparam int BYTE_WIDTH     = 8;
    localparam int BYTES_PER_WORD = 4;

    // index of a byte within a word
    localparam int LANE_WIDTH = $clog2(BYTES_PER_WORD);

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [BYTE_WIDTH-1:0] byte_t;
    typedef logic [LANE_WIDTH-1:0] lane_t;

    // data access size, 1, 2 or 4 bytes
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } accessSize_t;

    // one per issued byte, sequencer to assembler
    typedef struct packed {
        logic valid;
        logic isFetch;
        logic isStore;
        logic last;
    } memBeat_t;

    // ram side of the sequencer
    typedef struct packed {
        logic  write;
        addr_t addr;
        byte_t data;
    } memBusOut_t;

endpackage

`default_nettype wire

// File: memCtrlTb.sv
`default_nettype none

module memCtrlTb;

    localparam int RAM_BYTES  = 4096;
    localparam int FETCH_SPAN = 2048;
    localparam int DATA_BASE  = 2048;
    localparam int DATA_SPAN  = 256;
    localparam int WAIT_LIMIT = 400;

    logic clk;
    logic rst;
    logic i_rdy;
    logic i_ioBufferFull;

    memCtrlPkg::byte_t       i_memData;
    logic                    o_memWrite;
    memCtrlPkg::addr_t       o_memAddr;
    memCtrlPkg::byte_t       o_memData;

    logic                    i_fetchEn;
    memCtrlPkg::addr_t       i_fetchAddr;
    logic                    o_fetchDone;
    memCtrlPkg::word_t       o_fetchInst;

    logic                    i_dcEn;
    logic                    i_dcStore;
    memCtrlPkg::accessSize_t i_dcSize;
    memCtrlPkg::addr_t       i_dcAddr;
    memCtrlPkg::word_t       i_dcData;
    logic                    o_dcDone;
    memCtrlPkg::word_t       o_dcData;

    // ram behind the controller and the expected contents
    memCtrlPkg::byte_t ram   [RAM_BYTES];
    memCtrlPkg::byte_t model [RAM_BYTES];

    int   errorCount;
    int   timeoutCount;
    int   checkCount;
    logic stallEn;
    time  fetchDoneTime;
    time  dcDoneTime;
    logic fetchDonePrev;
    logic dcDonePrev;

    memCtrl UUT (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_memData      (i_memData),
        .o_memWrite     (o_memWrite),
        .o_memAddr      (o_memAddr),
        .o_memData      (o_memData),
        .i_fetchEn      (i_fetchEn),
        .i_fetchAddr    (i_fetchAddr),
        .o_fetchDone    (o_fetchDone),
        .o_fetchInst    (o_fetchInst),
        .i_dcEn         (i_dcEn),
        .i_dcStore      (i_dcStore),
        .i_dcSize       (i_dcSize),
        .i_dcAddr       (i_dcAddr),
        .i_dcData       (i_dcData),
        .o_dcDone       (o_dcDone),
        .o_dcData       (o_dcData)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // synchronous ram with registered read data
    always @(posedge clk) begin
        if (o_memWrite === 1'b1) begin
            ram[o_memAddr[11:0]] <= o_memData;
            if (!i_rdy || i_ioBufferFull) begin
                $display("ERROR %0t: write to %h during a stall cycle", $time, o_memAddr);
                errorCount++;
            end
        end
        i_memData <= ram[o_memAddr[11:0]];
    end

    // done strobes last one cycle and never overlap
    always @(posedge clk) begin
        if (rst) begin
            fetchDonePrev <= 1'b0;
            dcDonePrev    <= 1'b0;
        end else begin
            if (o_fetchDone && o_dcDone) begin
                $display("ERROR %0t: fetch done and data done high together", $time);
                errorCount++;
            end
            if (o_fetchDone && fetchDonePrev) begin
                $display("ERROR %0t: fetch done held longer than one cycle", $time);
                errorCount++;
            end
            if (o_dcDone && dcDonePrev) begin
                $display("ERROR %0t: data done held longer than one cycle", $time);
                errorCount++;
            end
            fetchDonePrev <= o_fetchDone;
            dcDonePrev    <= o_dcDone;
        end
    end

    function automatic memCtrlPkg::word_t modelWord(input memCtrlPkg::addr_t addr,
                                                    input int nBytes);
        memCtrlPkg::word_t w;
        int k;
        w = '0;
        for (k = 0; k < nBytes; k++) begin
            w[k*8 +: 8] = model[addr + k];
        end
        return w;
    endfunction

    task automatic fetchWord(input memCtrlPkg::addr_t addr, input bit checkLatency);
        memCtrlPkg::word_t expected;
        int cycles;
        expected    = modelWord(addr, 4);
        i_fetchEn   = 1'b1;
        i_fetchAddr = addr;
        @(negedge clk);
        cycles = 1;
        while (!o_fetchDone && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_fetchDone) begin
            $display("timeout: fetch from %h saw no done within %0d cycles", addr, WAIT_LIMIT);
            timeoutCount++;
        end else begin
            fetchDoneTime = $time;
            checkCount++;
            if (o_fetchInst !== expected) begin
                $display("ERROR %0t: fetch %h gave %h, expected %h",
                         $time, addr, o_fetchInst, expected);
                errorCount++;
            end
            if (checkLatency && cycles != 5) begin
                $display("ERROR %0t: fetch %h took %0d cycles, expected 5", $time, addr, cycles);
                errorCount++;
            end
        end
        i_fetchEn = 1'b0;
    endtask

    task automatic dataAccess(input logic store, input memCtrlPkg::accessSize_t size,
                              input memCtrlPkg::addr_t addr, input memCtrlPkg::word_t data,
                              input bit checkLatency);
        memCtrlPkg::word_t expected;
        int nBytes;
        int cycles;
        int k;
        nBytes = 1 << int'(size);
        // stores answer with zero data
        expected  = store ? '0 : modelWord(addr, nBytes);
        i_dcEn    = 1'b1;
        i_dcStore = store;
        i_dcSize  = size;
        i_dcAddr  = addr;
        i_dcData  = data;
        @(negedge clk);
        cycles = 1;
        while (!o_dcDone && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_dcDone) begin
            $display("timeout: data access at %h saw no done within %0d cycles",
                     addr, WAIT_LIMIT);
            timeoutCount++;
        end else begin
            dcDoneTime = $time;
            checkCount++;
            if (o_dcData !== expected) begin
                $display("ERROR %0t: %s of %0d bytes at %h gave %h, expected %h", $time,
                         store ? "store" : "load", nBytes, addr, o_dcData, expected);
                errorCount++;
            end
            if (checkLatency && cycles != nBytes + 1) begin
                $display("ERROR %0t: access at %h took %0d cycles, expected %0d",
                         $time, addr, cycles, nBytes + 1);
                errorCount++;
            end
            if (store) begin
                for (k = 0; k < nBytes; k++) begin
                    model[addr + k] = data[k*8 +: 8];
                end
            end
        end
        i_dcEn = 1'b0;
    endtask

    task automatic randomFetches(input int count, input bit checkLatency);
        memCtrlPkg::addr_t addr;
        repeat (count) begin
            addr = memCtrlPkg::addr_t'($urandom_range(0, FETCH_SPAN / 4 - 1) * 4);
            fetchWord(addr, checkLatency);
            repeat ($urandom_range(1, 4)) @(negedge clk);
        end
    endtask

    task automatic randomAccesses(input int count, input bit checkLatency);
        memCtrlPkg::accessSize_t size;
        memCtrlPkg::addr_t       addr;
        int                      nBytes;
        repeat (count) begin
            size   = memCtrlPkg::accessSize_t'($urandom_range(0, 2));
            nBytes = 1 << int'(size);
            // small window so loads often hit earlier stores
            addr   = memCtrlPkg::addr_t'(DATA_BASE +
                                         $urandom_range(0, DATA_SPAN / nBytes - 1) * nBytes);
            dataAccess($urandom_range(0, 1), size, addr, $urandom, checkLatency);
            repeat ($urandom_range(1, 4)) @(negedge clk);
        end
    endtask

    initial begin
        int k;
        int mismatches;
        memCtrlPkg::addr_t fetchAddr;
        memCtrlPkg::addr_t dataAddr;
        rst            = 1'b1;
        i_rdy          = 1'b1;
        i_ioBufferFull = 1'b0;
        i_memData      = '0;
        i_fetchEn      = 1'b0;
        i_fetchAddr    = '0;
        i_dcEn         = 1'b0;
        i_dcStore      = 1'b0;
        i_dcSize       = memCtrlPkg::SIZE_BYTE;
        i_dcAddr       = '0;
        i_dcData       = '0;
        stallEn        = 1'b0;
        errorCount     = 0;
        timeoutCount   = 0;
        checkCount     = 0;
        mismatches     = 0;
        void'($urandom(32'hc83db8ef));

        for (k = 0; k < RAM_BYTES; k++) begin
            ram[k]   = memCtrlPkg::byte_t'($urandom);
            model[k] = ram[k];
        end

        // stall generator
        fork
            forever begin
                @(negedge clk);
                if (stallEn) begin
                    i_rdy          = ($urandom_range(0, 7) != 0);
                    i_ioBufferFull = ($urandom_range(0, 7) == 0);
                end else begin
                    i_rdy          = 1'b1;
                    i_ioBufferFull = 1'b0;
                end
            end
        join_none

        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);

        // one requester at a time with exact latency
        randomFetches(10, 1'b1);
        randomAccesses(40, 1'b1);

        // both enables raised together so the data port goes first
        repeat (8) begin
            fetchAddr = memCtrlPkg::addr_t'($urandom_range(0, FETCH_SPAN / 4 - 1) * 4);
            dataAddr  = memCtrlPkg::addr_t'(DATA_BASE +
                                            $urandom_range(0, DATA_SPAN / 4 - 1) * 4);
            fork
                fetchWord(fetchAddr, 1'b0);
                dataAccess(1'b0, memCtrlPkg::SIZE_WORD, dataAddr, '0, 1'b1);
            join
            if (dcDoneTime >= fetchDoneTime) begin
                $display("ERROR %0t: data done at %0t did not come before fetch done at %0t",
                         $time, dcDoneTime, fetchDoneTime);
                errorCount++;
            end
            @(negedge clk);
        end

        // both requesters with random stalls
        stallEn = 1'b1;
        fork
            randomFetches(150, 1'b0);
            randomAccesses(250, 1'b0);
        join
        stallEn = 1'b0;
        repeat (4) @(negedge clk);

        for (k = 0; k < RAM_BYTES; k++) begin
            if (ram[k] !== model[k]) begin
                $display("ERROR %0t: ram byte %h is %h, expected %h", $time, k, ram[k], model[k]);
                mismatches++;
            end
        end
        errorCount += mismatches;

        $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: memCtrl_props.sv
`default_nettype none

module memCtrlProps (
    input logic clk,
    input logic rst,
    input logic i_rdy,
    input logic i_ioBufferFull,
    input logic o_memWrite,
    input logic o_fetchDone,
    input logic o_dcDone
);

    noWriteInStall: assert property (@(posedge clk) disable iff (rst)
        o_memWrite |-> (i_rdy && !i_ioBufferFull))
        else $error("write strobe high in a stall cycle");

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        o_fetchDone |=> !o_fetchDone)
        else $error("fetch done held longer than one cycle");

    dcDonePulse: assert property (@(posedge clk) disable iff (rst)
        o_dcDone |=> !o_dcDone)
        else $error("data done held longer than one cycle");

    // one request in flight, so never both
    donesExclusive: assert property (@(posedge clk) disable iff (rst)
        !(o_fetchDone && o_dcDone))
        else $error("fetch done and data done high together");

endmodule

bind memCtrl memCtrlProps props (
    .clk            (clk),
    .rst            (rst),
    .i_rdy          (i_rdy),
    .i_ioBufferFull (i_ioBufferFull),
    .o_memWrite     (o_memWrite),
    .o_fetchDone    (o_fetchDone),
    .o_dcDone       (o_dcDone)
);

`default_nettype wire

// File: memWordAssembler.sv
`default_nettype none

module memWordAssembler (
    input  logic                 clk,
    input  logic                 rst,

    input  memCtrlPkg::memBeat_t i_beat,
    input  memCtrlPkg::byte_t    i_memData,

    output logic                 o_fetchDone,
    output memCtrlPkg::word_t    o_fetchInst,
    output logic                 o_dcDone,
    output memCtrlPkg::word_t    o_dcData
);

    // beat delayed one cycle to meet the ram read data
    memCtrlPkg::memBeat_t beatQ;

    memCtrlPkg::lane_t laneIdx;
    memCtrlPkg::word_t wordQ;
    memCtrlPkg::word_t assembled;

    logic fetchEnd;
    logic dcEnd;

    // current byte merged into its lane
    always_comb begin
        assembled = wordQ;
        assembled[laneIdx*memCtrlPkg::BYTE_WIDTH +: memCtrlPkg::BYTE_WIDTH] = i_memData;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beatQ   <= '0;
            laneIdx <= '0;
            wordQ   <= '0;
        end else begin
            beatQ <= i_beat;
            if (beatQ.valid) begin
                if (beatQ.last) begin
                    // clear for the next request, keeps short loads zero-extended
                    laneIdx <= '0;
                    wordQ   <= '0;
                end else begin
                    laneIdx <= laneIdx + memCtrlPkg::lane_t'(1);
                    if (!beatQ.isStore) begin
                        wordQ <= assembled;
                    end
                end
            end
        end
    end

    assign fetchEnd = beatQ.valid && beatQ.last && beatQ.isFetch;
    assign dcEnd    = beatQ.valid && beatQ.last && !beatQ.isFetch;

    assign o_fetchDone = fetchEnd;
    assign o_dcDone    = dcEnd;

    assign o_fetchInst = fetchEnd ? assembled : '0;

    // stores report done with zero data
    assign o_dcData = (dcEnd && !beatQ.isStore) ? assembled : '0;

endmodule

`default_nettype wire
